// File: verilog/eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

	////////////////////////////////////////
	// Widths with a meaning

	// One GMII data byte
	typedef logic [7:0] gmii_byte_t;

	// Upper-layer word, first byte in bits 31:24
	typedef logic [31:0] rx_word_t;

	// CRC-32 value
	typedef logic [31:0] crc_t;

	// Valid byte lanes in a word, 0 to 4
	typedef logic [2:0] byte_count_t;

	// Wrapping performance counter
	typedef logic [31:0] perf_count_t;

	////////////////////////////////////////
	// Buses

	// GMII receive lane
	// dvalid is the byte enable at 10/100
	typedef struct packed {
		logic       en;
		logic       er;
		logic       dvalid;
		gmii_byte_t data;
	} gmii_rx_t;

	// Receive bus to the upper layer, all strobes last one cycle
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		rx_word_t    data;
		logic        commit;
		logic        drop;
	} mac_rx_bus_t;

	// Receive performance counters
	typedef struct packed {
		perf_count_t rx_frames;
		perf_count_t rx_crc_err;
		perf_count_t rx_bytes;
	} mac_rx_perf_t;

	// Preamble/SFD decoder states
	typedef enum logic [1:0] {
		RX_IDLE       = 2'd0,
		RX_PREAMBLE   = 2'd1,
		RX_FRAME_DATA = 2'd2,
		RX_DROP       = 2'd3
	} rx_state_t;

	////////////////////////////////////////
	// Protocol constants

	localparam gmii_byte_t PREAMBLE_BYTE = 8'h55;
	localparam gmii_byte_t SFD_BYTE = 8'hD5;

	// Trailing FCS length in bytes
	localparam byte_count_t FCS_BYTES = 3'd4;

	// Reflected Ethernet CRC-32
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
	localparam crc_t CRC_POLY_REFLECTED = 32'hEDB8_8320;

endpackage

`default_nettype wire

// File: verilog/rx_frame_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module rx_frame_decoder (
	input  logic                   gmii_rx_clk,
	input  logic                   rst_n,
	input  eth_rx_pkg::gmii_rx_t   gmii_rx,
	output logic                   frame_start,
	output logic                   byte_valid,
	output logic                   frame_end,
	output eth_rx_pkg::gmii_byte_t byte_data
);

	import eth_rx_pkg::*;

	rx_state_t state;

	////////////////////////////////////////
	// Preamble/SFD state machine

	// Everything advances on dvalid cycles only
	// Outputs are registered, one cycle behind the input byte
	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= RX_IDLE;
			frame_start <= 1'b0;
			byte_valid  <= 1'b0;
			frame_end   <= 1'b0;
		end else begin
			// Strobes default low
			frame_start <= 1'b0;
			byte_valid  <= 1'b0;
			frame_end   <= 1'b0;

			if (gmii_rx.dvalid) begin
				case (state)
					RX_IDLE: begin
						// er outside a frame is ignored until en rises
						if (gmii_rx.en) begin
							if (gmii_rx.data == PREAMBLE_BYTE && !gmii_rx.er)
								state <= RX_PREAMBLE;
							else
								state <= RX_DROP;
						end
					end

					RX_PREAMBLE: begin
						// Truncated during preamble, nothing was announced
						if (!gmii_rx.en) begin
							state <= RX_IDLE;
						end else if (gmii_rx.data == SFD_BYTE) begin
							frame_start <= 1'b1;
							state       <= RX_FRAME_DATA;
						end else if (gmii_rx.data != PREAMBLE_BYTE) begin
							// Junk before SFD
							state <= RX_DROP;
						end
					end

					RX_FRAME_DATA: begin
						if (gmii_rx.en) begin
							byte_valid <= 1'b1;
						end else begin
							// First dvalid cycle with en low ends the frame
							frame_end <= 1'b1;
							state     <= RX_IDLE;
						end
					end

					RX_DROP: begin
						// Swallow the rest of a bad frame
						if (!gmii_rx.en)
							state <= RX_IDLE;
					end

					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Byte payload, qualified by byte_valid
	always_ff @(posedge gmii_rx_clk) begin
		if (gmii_rx.dvalid && gmii_rx.en)
			byte_data <= gmii_rx.data;
	end

	////////////////////////////////////////
	// Checks

	// A frame byte must come from a cycle spent in frame data
	assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		byte_valid |-> $past(state) == RX_FRAME_DATA);

endmodule

`default_nettype wire

// File: verilog/rx_crc32.sv
`default_nettype none
`timescale 1ns/100ps

module rx_crc32 (
	input  logic                   gmii_rx_clk,
	input  logic                   rst_n,
	input  logic                   clear,
	input  logic                   update,
	input  eth_rx_pkg::gmii_byte_t din,
	output eth_rx_pkg::crc_t       crc
);

	import eth_rx_pkg::*;

	crc_t crc_reg;

	// One byte through the reflected polynomial, LSB first
	function automatic crc_t crc_next(input crc_t cur, input gmii_byte_t d);
		crc_t c;
		c = cur;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i])
				c = (c >> 1) ^ CRC_POLY_REFLECTED;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Clear wins over update
	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n)
			crc_reg <= CRC_INIT;
		else if (clear)
			crc_reg <= CRC_INIT;
		else if (update)
			crc_reg <= crc_next(crc_reg, din);
	end

	// Final XOR, this is the value that goes on the wire
	assign crc = ~crc_reg;

endmodule

`default_nettype wire

// File: verilog/rx_word_packer.sv
`default_nettype none
`timescale 1ns/100ps

module rx_word_packer (
	input  logic                    gmii_rx_clk,
	input  logic                    rst_n,
	input  logic                    frame_start,
	input  logic                    byte_valid,
	input  logic                    frame_end,
	input  eth_rx_pkg::gmii_byte_t  byte_data,
	output logic                    word_valid,
	output logic                    frame_done,
	output logic                    crc_match,
	output eth_rx_pkg::rx_word_t    word_data,
	output eth_rx_pkg::byte_count_t word_bytes
);

	import eth_rx_pkg::*;

	// Last four bytes seen, oldest in bits 31:24
	rx_word_t    hold;
	byte_count_t hold_cnt;

	// Released payload bytes of the current word
	rx_word_t    word_buf;
	byte_count_t word_cnt;

	logic        release_byte;
	gmii_byte_t  released;
	crc_t        crc;
	rx_word_t    fcs_expected;
	logic [5:0]  pad_bits;

	// Hold-back full, so the oldest byte is payload
	assign release_byte = byte_valid && (hold_cnt == FCS_BYTES);
	assign released = hold[31:24];

	// FCS goes out lowest CRC byte first
	assign fcs_expected = {crc[7:0], crc[15:8], crc[23:16], crc[31:24]};

	// Left-align shift for the last partial word
	assign pad_bits = {3'd4 - word_cnt, 3'b000};

	// CRC over released bytes only, never the FCS
	rx_crc32 u_crc (
		.gmii_rx_clk (gmii_rx_clk),
		.rst_n       (rst_n),
		.clear       (frame_start),
		.update      (release_byte),
		.din         (released),
		.crc         (crc)
	);

	////////////////////////////////////////
	// Control and strobes

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt   <= '0;
			word_cnt   <= '0;
			word_valid <= 1'b0;
			word_bytes <= '0;
			frame_done <= 1'b0;
			crc_match  <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			word_bytes <= '0;
			frame_done <= 1'b0;

			if (frame_start) begin
				hold_cnt <= '0;
				word_cnt <= '0;
			end else if (byte_valid) begin
				// Count up to a full hold-back, then saturate
				if (hold_cnt != FCS_BYTES)
					hold_cnt <= hold_cnt + 3'd1;
				if (release_byte) begin
					if (word_cnt == 3'd3) begin
						word_valid <= 1'b1;
						word_bytes <= 3'd4;
						word_cnt   <= '0;
					end else begin
						word_cnt <= word_cnt + 3'd1;
					end
				end
			end else if (frame_end) begin
				frame_done <= 1'b1;
				// Runt frames never match
				crc_match  <= (hold_cnt == FCS_BYTES) && (hold == fcs_expected);
				// Flush the tail word
				if (word_cnt != 3'd0) begin
					word_valid <= 1'b1;
					word_bytes <= word_cnt;
				end
				hold_cnt <= '0;
				word_cnt <= '0;
			end
		end
	end

	////////////////////////////////////////
	// Data path

	always_ff @(posedge gmii_rx_clk) begin
		if (byte_valid)
			hold <= {hold[23:0], byte_data};
		if (release_byte) begin
			word_buf <= {word_buf[23:0], released};
			if (word_cnt == 3'd3)
				word_data <= {word_buf[23:0], released};
		end else if (frame_end) begin
			word_data <= word_buf << pad_bits;
		end
	end

	// Emitted words always carry data
	assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		word_valid |-> word_bytes inside {[3'd1:3'd4]});

endmodule

`default_nettype wire

// File: verilog/rx_frame_checker.sv
`default_nettype none
`timescale 1ns/100ps

module rx_frame_checker (
	input  logic                     gmii_rx_clk,
	input  logic                     rst_n,
	input  logic                     word_valid,
	input  logic                     frame_done,
	input  logic                     crc_match,
	input  eth_rx_pkg::byte_count_t  word_bytes,
	output logic                     commit,
	output logic                     drop,
	output eth_rx_pkg::mac_rx_perf_t perf
);

	import eth_rx_pkg::*;

	logic good_frame;
	logic bad_frame;

	// crc_match is only meaningful with frame_done
	assign good_frame = frame_done && crc_match;
	assign bad_frame = frame_done && !crc_match;

	////////////////////////////////////////
	// Frame outcome

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			commit <= 1'b0;
			drop   <= 1'b0;
		end else begin
			commit <= good_frame;
			drop   <= bad_frame;
		end
	end

	////////////////////////////////////////
	// Performance counters

	// All three wrap at 2^32
	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			perf <= '0;
		end else begin
			if (good_frame)
				perf.rx_frames <= perf.rx_frames + perf_count_t'(1);
			if (bad_frame)
				perf.rx_crc_err <= perf.rx_crc_err + perf_count_t'(1);
			// Payload bytes only, FCS excluded
			if (word_valid)
				perf.rx_bytes <= perf.rx_bytes + perf_count_t'(word_bytes);
		end
	end

	// Exactly one outcome per finished frame, and none without one
	assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		(commit || drop) |-> ($past(frame_done) && !(commit && drop)));

endmodule

`default_nettype wire

// File: verilog/eth_rx_mac.sv
`default_nettype none
`timescale 1ns/100ps

module eth_rx_mac (
	input  logic                     gmii_rx_clk,
	input  logic                     rst_n,
	input  eth_rx_pkg::gmii_rx_t     gmii_rx,
	output eth_rx_pkg::mac_rx_bus_t  rx_bus,
	output eth_rx_pkg::mac_rx_perf_t perf
);

	import eth_rx_pkg::*;

	// Decoder events
	logic        frame_start;
	logic        byte_valid;
	logic        frame_end;
	gmii_byte_t  byte_data;

	// Packer results
	logic        word_valid;
	logic        frame_done;
	logic        crc_match;
	rx_word_t    word_data;
	byte_count_t word_bytes;

	// Checker outcome
	logic        commit;
	logic        drop;

	rx_frame_decoder u_decoder (
		.gmii_rx_clk (gmii_rx_clk),
		.rst_n       (rst_n),
		.gmii_rx     (gmii_rx),
		.frame_start (frame_start),
		.byte_valid  (byte_valid),
		.frame_end   (frame_end),
		.byte_data   (byte_data)
	);

	rx_word_packer u_packer (
		.gmii_rx_clk (gmii_rx_clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.byte_valid  (byte_valid),
		.frame_end   (frame_end),
		.byte_data   (byte_data),
		.word_valid  (word_valid),
		.frame_done  (frame_done),
		.crc_match   (crc_match),
		.word_data   (word_data),
		.word_bytes  (word_bytes)
	);

	rx_frame_checker u_checker (
		.gmii_rx_clk (gmii_rx_clk),
		.rst_n       (rst_n),
		.word_valid  (word_valid),
		.frame_done  (frame_done),
		.crc_match   (crc_match),
		.word_bytes  (word_bytes),
		.commit      (commit),
		.drop        (drop),
		.perf        (perf)
	);

	// Upper-layer bus, start one cycle after SFD
	always_comb begin
		rx_bus.start       = frame_start;
		rx_bus.data_valid  = word_valid;
		rx_bus.bytes_valid = word_bytes;
		rx_bus.data        = word_data;
		rx_bus.commit      = commit;
		rx_bus.drop        = drop;
	end

endmodule

`default_nettype wire

// File: include/tb_rx_model.svh
`ifndef TB_RX_MODEL_SVH
`define TB_RX_MODEL_SVH

////////////////////////////////////////
// Reference model state

// One entry per cycle that carries a strobe on rx_bus
mac_rx_bus_t exp_q[$];

// Bytes after the SFD of the frame under test, FCS included
gmii_byte_t frame_q[$];

// Running totals the perf counters must reach
perf_count_t exp_frames;
perf_count_t exp_crc_err;
perf_count_t exp_bytes;

// Standard Ethernet CRC-32, reflected, byte-wise
function automatic crc_t calc_crc32(input gmii_byte_t data[$]);
	logic [31:0] r;
	r = 32'hFFFF_FFFF;
	foreach (data[i]) begin
		r = r ^ {24'h0, data[i]};
		for (int b = 0; b < 8; b++)
			r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
	end
	return ~r;
endfunction

// Random payload, FCS appended lowest byte first
function automatic void build_frame(input int payload_len, input bit corrupt);
	crc_t fcs;
	int pos;
	frame_q.delete();
	for (int i = 0; i < payload_len; i++)
		frame_q.push_back(gmii_byte_t'($urandom));
	fcs = calc_crc32(frame_q);
	frame_q.push_back(fcs[7:0]);
	frame_q.push_back(fcs[15:8]);
	frame_q.push_back(fcs[23:16]);
	frame_q.push_back(fcs[31:24]);
	// One damaged byte, payload or FCS
	if (corrupt) begin
		pos = $urandom_range(frame_q.size() - 1, 0);
		frame_q[pos] = frame_q[pos] ^ gmii_byte_t'($urandom_range(255, 1));
	end
endfunction

// Too short to hold an FCS
function automatic void build_runt(input int len);
	frame_q.delete();
	for (int i = 0; i < len; i++)
		frame_q.push_back(gmii_byte_t'($urandom));
endfunction

// Start, payload words, then the outcome
function automatic void expect_frame();
	gmii_byte_t payload[$];
	crc_t fcs;
	mac_rx_bus_t ev;
	int n;
	int cnt;
	bit good;
	n = frame_q.size();
	ev = '0;
	ev.start = 1'b1;
	exp_q.push_back(ev);
	good = 1'b0;
	if (n >= 4) begin
		for (int i = 0; i < n - 4; i++)
			payload.push_back(frame_q[i]);
		fcs = {frame_q[n-1], frame_q[n-2], frame_q[n-3], frame_q[n-4]};
		good = (calc_crc32(payload) == fcs);
		// First byte lands in the top lane, tail word left-aligned
		for (int i = 0; i < payload.size(); i += 4) begin
			ev = '0;
			ev.data_valid = 1'b1;
			cnt = (payload.size() - i > 4) ? 4 : payload.size() - i;
			for (int k = 0; k < cnt; k++)
				ev.data[31 - 8 * k -: 8] = payload[i + k];
			ev.bytes_valid = byte_count_t'(cnt);
			exp_q.push_back(ev);
		end
		exp_bytes = exp_bytes + perf_count_t'(payload.size());
	end
	ev = '0;
	ev.commit = good;
	ev.drop = !good;
	exp_q.push_back(ev);
	if (good)
		exp_frames = exp_frames + perf_count_t'(1);
	else
		exp_crc_err = exp_crc_err + perf_count_t'(1);
endfunction

`endif

// File: testbench/tb_eth_rx_mac.sv
`default_nettype none
`timescale 1ns/100ps

module tb_eth_rx_mac;

	import eth_rx_pkg::*;

	localparam logic [31:0] SEED = 32'ha10ff3fc;
	localparam int NUM_FRAMES = 60;
	localparam int MAX_PAYLOAD = 80;
	localparam int GAP_BYTES = 12;
	localparam int TIMEOUT_CYCLES = 2000;

	logic         gmii_rx_clk;
	logic         rst_n;
	gmii_rx_t     gmii_rx;
	mac_rx_bus_t  rx_bus;
	mac_rx_perf_t perf;

	mac_rx_bus_t  seen_ev;
	gmii_byte_t   ref_q[$];

	`include "tb_rx_model.svh"

	eth_rx_mac u_dut (
		.gmii_rx_clk (gmii_rx_clk),
		.rst_n       (rst_n),
		.gmii_rx     (gmii_rx),
		.rx_bus      (rx_bus),
		.perf        (perf)
	);

	initial begin
		gmii_rx_clk = 1'b0;
		forever #50 gmii_rx_clk = ~gmii_rx_clk;
	end

	////////////////////////////////////////
	// Reporting

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t: %s got 0x%h expected 0x%h",
				$time, name, got, exp));
	endtask

	////////////////////////////////////////
	// GMII driver

	// Gapped mode idles 0 to 4 cycles before each byte
	// dvalid is then high about one cycle in three
	task automatic drive_byte(input logic en, input logic er, input gmii_byte_t data,
			input bit gapped);
		int idle;
		idle = gapped ? $urandom_range(4, 0) : 0;
		for (int k = 0; k < idle; k++) begin
			@(posedge gmii_rx_clk);
			gmii_rx <= '{en: en, er: er, dvalid: 1'b0, data: data};
		end
		@(posedge gmii_rx_clk);
		gmii_rx <= '{en: en, er: er, dvalid: 1'b1, data: data};
	endtask

	// The first byte with en low ends a frame
	task automatic send_gap(input bit gapped);
		for (int i = 0; i < GAP_BYTES; i++)
			drive_byte(1'b0, 1'b0, 8'h00, gapped);
	endtask

	// Preamble, SFD and frame_q, then the gap
	task automatic send_frame(input bit gapped);
		int len;
		len = $urandom_range(7, 1);
		for (int i = 0; i < len; i++)
			drive_byte(1'b1, 1'b0, PREAMBLE_BYTE, gapped);
		drive_byte(1'b1, 1'b0, SFD_BYTE, gapped);
		foreach (frame_q[i])
			drive_byte(1'b1, 1'b0, frame_q[i], gapped);
		send_gap(gapped);
	endtask

	// No strobe may reach rx_bus after a fault before the SFD
	task automatic run_preamble_fault(input int fault, input bit gapped);
		int len;
		int pos;
		len = $urandom_range(7, 1);
		pos = $urandom_range(len - 1, 0);
		build_frame($urandom_range(MAX_PAYLOAD, 1), 1'b0);
		for (int i = 0; i < len; i++) begin
			if (fault == 0 && i == pos)
				// Values below 0x55 are neither preamble nor SFD
				drive_byte(1'b1, 1'b0, gmii_byte_t'($urandom_range(8'h54, 0)), gapped);
			else
				drive_byte(1'b1, fault == 1 && i == 0, PREAMBLE_BYTE, gapped);
		end
		// Truncated frames stop here
		if (fault != 2) begin
			drive_byte(1'b1, 1'b0, SFD_BYTE, gapped);
			foreach (frame_q[i])
				drive_byte(1'b1, 1'b0, frame_q[i], gapped);
		end
		send_gap(gapped);
	endtask

	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
			@(posedge gmii_rx_clk);
			cycles++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("Timed out waiting for %s, %0d events still expected",
				what, exp_q.size()));
	endtask

	////////////////////////////////////////
	// Monitor

	// Sampled on the falling edge, away from the driving edge
	always @(negedge gmii_rx_clk) begin
		if (rst_n && (rx_bus.start || rx_bus.data_valid || rx_bus.commit || rx_bus.drop)) begin
			if (exp_q.size() == 0) begin
				abort_run($sformatf("Unexpected strobe on rx_bus at %0t", $time));
			end else begin
				seen_ev = exp_q.pop_front();
				check_value("rx_bus.start", rx_bus.start, seen_ev.start);
				check_value("rx_bus.data_valid", rx_bus.data_valid, seen_ev.data_valid);
				check_value("rx_bus.commit", rx_bus.commit, seen_ev.commit);
				check_value("rx_bus.drop", rx_bus.drop, seen_ev.drop);
				if (seen_ev.data_valid) begin
					check_value("rx_bus.bytes_valid", rx_bus.bytes_valid, seen_ev.bytes_valid);
					check_value("rx_bus.data", rx_bus.data, seen_ev.data);
				end
			end
		end
	end

	////////////////////////////////////////
	// Stimulus

	initial begin
		bit gapped;
		void'($urandom(SEED));
		gmii_rx = '0;
		rst_n = 1'b0;
		exp_frames = '0;
		exp_crc_err = '0;
		exp_bytes = '0;

		// Model CRC against the well-known check value
		for (int i = 0; i < 9; i++)
			ref_q.push_back(gmii_byte_t'(8'h31 + i));
		check_value("model crc32", calc_crc32(ref_q), 32'hCBF4_3926);

		repeat (8) @(posedge gmii_rx_clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge gmii_rx_clk);

		// Every frame kind runs back-to-back and with dvalid gaps
		for (int i = 0; i < NUM_FRAMES; i++) begin
			gapped = ((i / 5) % 2) == 1;
			case (i % 5)
				0, 1: begin
					build_frame($urandom_range(MAX_PAYLOAD, 1), 1'b0);
					expect_frame();
					send_frame(gapped);
				end
				2: begin
					build_frame($urandom_range(MAX_PAYLOAD, 1), 1'b1);
					expect_frame();
					send_frame(gapped);
				end
				3: run_preamble_fault($urandom_range(2, 0), gapped);
				default: begin
					build_runt($urandom_range(3, 0));
					expect_frame();
					send_frame(gapped);
				end
			endcase
			wait_drained($sformatf("the rx_bus events of frame %0d", i));
		end

		// Let the counters settle
		repeat (4) @(posedge gmii_rx_clk);
		check_value("perf.rx_frames", perf.rx_frames, exp_frames);
		check_value("perf.rx_crc_err", perf.rx_crc_err, exp_crc_err);
		check_value("perf.rx_bytes", perf.rx_bytes, exp_bytes);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
verilog/eth_rx_pkg.sv
verilog/rx_frame_decoder.sv
verilog/rx_crc32.sv
verilog/rx_word_packer.sv
verilog/rx_frame_checker.sv
verilog/eth_rx_mac.sv
testbench/tb_eth_rx_mac.sv

// File: Bender.yml
package:
  name: eth_rx_mac

dependencies: {}

sources:
  # Package first, then the receive path bottom-up
  - files:
      - verilog/eth_rx_pkg.sv
      - verilog/rx_frame_decoder.sv
      - verilog/rx_crc32.sv
      - verilog/rx_word_packer.sv
      - verilog/rx_frame_checker.sv
      - verilog/eth_rx_mac.sv

  # Testbench with its reference model header
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_eth_rx_mac.sv
